//--- verilog.f
logic/exec_cfg_pkg.sv
logic/exec_op_pkg.sv
logic/issue_dispatch.sv
logic/alu.sv
logic/serial_mult.sv
logic/wb_arbiter.sv
logic/exec_unit.sv
verif/tb_clk_gen.sv
verif/tb_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f verilog.f --top-module tb_exec_unit \
    && ./obj_dir/Vtb_exec_unit | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

//--- verif/tb_exec_unit.sv
/* Execute stage testbench, random and directed operations
   checked by assertions on the writeback bus */
module tb_exec_unit;
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    // ALU operations use ids 0 to 6, the multiply owns id 7
    localparam tid_t        MUL_TID    = 3'd7;
    localparam int unsigned WAIT_LIMIT = 200;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    fu_op_t      issue_op;
    xlen_t       issue_a;
    xlen_t       issue_b;
    tid_t        issue_tid;
    logic        busy;
    logic        wb_valid;
    tid_t        wb_tid;
    xlen_t       wb_result;
    logic        wb_branch;

    int          seed = 29;
    int          errors = 0;
    string       test_name = "reset";
    int unsigned cycle = 0;
    int unsigned mul_cycle = 0;
    tid_t        alu_tid = '0;
    logic        prev_alu;
    tid_t        prev_tid;
    logic        mul_open;
    logic        mul_wb;
    logic        mul_ready;
    xlen_t       exp_result [2**TID_W];
    logic        exp_branch [2**TID_W];
    fu_op_t      br_ops [6] = '{EQ, NE, LTS, LTU, GES, GEU};
    xlen_t       br_a [5] = '{32'd5, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h8000_0000};
    xlen_t       br_b [5] = '{32'd5, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h8000_0000};

    tb_clk_gen clk_gen_i (.clk_o (clk), .rst_n_o (rst_n));

    exec_unit dut_i (
        .clk_i (clk), .rst_n_i (rst_n), .issue_valid_i (issue_valid),
        .issue_op_i (issue_op), .issue_a_i (issue_a), .issue_b_i (issue_b),
        .issue_tid_i (issue_tid), .busy_o (busy), .wb_valid_o (wb_valid),
        .wb_tid_o (wb_tid), .wb_result_o (wb_result), .wb_branch_o (wb_branch)
    );

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic xlen_t model_result(fu_op_t op, xlen_t a, xlen_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            ANDL:    return a & b;
            ORL:     return a | b;
            XORL:    return a ^ b;
            SLL:     return a << b[SHAMT_W-1:0];
            SRL:     return a >> b[SHAMT_W-1:0];
            SRA:     return $unsigned($signed(a) >>> b[SHAMT_W-1:0]);
            SLTS:    return xlen_t'($signed(a) < $signed(b));
            SLTU:    return xlen_t'(a < b);
            MUL:     return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic logic model_branch(fu_op_t op, xlen_t a, xlen_t b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return $signed(a) < $signed(b);
            LTU:     return a < b;
            GES:     return $signed(a) >= $signed(b);
            GEU:     return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Issue history, one edge behind the DUT
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_alu <= 1'b0;
            mul_open <= 1'b0;
        end else begin
            prev_alu <= issue_valid && (issue_op != MUL);
            prev_tid <= issue_tid;
            cycle    <= cycle + 1;
            if (issue_valid && (issue_op == MUL)) begin
                mul_open  <= 1'b1;
                mul_cycle <= cycle;
            end else if (mul_wb) begin
                mul_open <= 1'b0;
            end
        end
    end

    assign mul_wb = wb_valid && (wb_tid == MUL_TID);
    // cycle holds the count of earlier edges, so +1 names the current one
    assign mul_ready = mul_open && ((cycle + 32'd1 - mul_cycle) >= (MUL_CYCLES + 32'd1));

    task automatic report_mismatch(string check, xlen_t exp_val, xlen_t act_val);
        errors++;
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, check, exp_val, act_val);
    endtask

    task automatic report_problem(string what);
        errors++;
        $display("ERROR in %s: %s", test_name, what);
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    a_alu_wb : assert property (@(posedge clk) disable iff (!rst_n)
        prev_alu |-> wb_valid && (wb_tid == prev_tid))
        else report_mismatch("alu valid,tid", xlen_t'({1'b1, $sampled(prev_tid)}),
                             xlen_t'({$sampled(wb_valid), $sampled(wb_tid)}));
    a_wb_result : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_result == exp_result[wb_tid])
        else report_mismatch("wb_result", exp_result[$sampled(wb_tid)], $sampled(wb_result));
    a_wb_branch : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_branch == exp_branch[wb_tid])
        else report_mismatch("wb_branch", xlen_t'(exp_branch[$sampled(wb_tid)]),
                             xlen_t'($sampled(wb_branch)));
    a_wb_source : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !prev_alu |-> mul_ready && (wb_tid == MUL_TID))
        else report_problem("writeback without an ALU issue or a finished multiply");
    a_mul_first_free : assert property (@(posedge clk) disable iff (!rst_n)
        mul_ready && !prev_alu |-> mul_wb)
        else report_problem("multiply result missed the first free writeback cycle");
    a_busy : assert property (@(posedge clk) disable iff (!rst_n)
        busy == mul_open)
        else report_mismatch("busy", xlen_t'($sampled(mul_open)), xlen_t'($sampled(busy)));

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic issue(fu_op_t op, xlen_t a, xlen_t b, tid_t tid);
        exp_result[tid] = (op inside {EQ, NE, LTS, LTU, GES, GEU}) ? '0 : model_result(op, a, b);
        exp_branch[tid] = model_branch(op, a, b);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_a     = a;
        issue_b     = b;
        issue_tid   = tid;
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic issue_alu(fu_op_t op, xlen_t a, xlen_t b);
        issue(op, a, b, alu_tid);
        alu_tid = (alu_tid == 3'd6) ? 3'd0 : alu_tid + 3'd1;
    endtask

    task automatic issue_random_alu(int count);
        logic [31:0] pick;
        for (int i = 0; i < count; i++) begin
            pick = $random(seed);
            issue_alu(fu_op_t'(5'(pick % 32'd10)), $random(seed), $random(seed));
        end
    endtask

    task automatic wait_mul_writeback();
        int unsigned n;
        n = 0;
        while (mul_open && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (mul_open) begin
            report_problem("timeout waiting for the multiply writeback");
        end
    endtask

    initial begin
        int unsigned n;
        issue_valid = 1'b0;
        issue_op    = ADD;
        issue_a     = '0;
        issue_b     = '0;
        issue_tid   = '0;
        n = 0;
        while (!rst_n && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            report_problem("timeout waiting for reset release");
        end
        // Idle bus after reset
        repeat (6) @(posedge clk);
        #2;
        test_name = "alu_random";
        issue_random_alu(64);
        test_name = "branch";
        for (int o = 0; o < 6; o++) begin
            for (int p = 0; p < 5; p++) begin
                issue_alu(br_ops[o], br_a[p], br_b[p]);
            end
            issue_alu(br_ops[o], $random(seed), $random(seed));
        end
        test_name = "multiply";
        issue(MUL, $random(seed), $random(seed), MUL_TID);
        wait_mul_writeback();
        issue(MUL, 32'hffff_ffff, 32'hffff_ffff, MUL_TID);
        wait_mul_writeback();
        // ALU stream runs past the multiply's completion
        test_name = "contention";
        issue(MUL, $random(seed), $random(seed), MUL_TID);
        issue_random_alu(int'(MUL_CYCLES) + 8);
        wait_mul_writeback();
        repeat (4) @(posedge clk);
        #2;
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
/* Testbench clock and reset, 20 unit clock period with
   reset held low for the first 10 cycles */
module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        // Release just after the edge, like the other stimulus
        #2 rst_n_o = 1'b1;
    end

endmodule

//--- logic/exec_unit.sv
/* Integer execute stage top, issue dispatch feeding an ALU and
   a serial multiplier that share one writeback bus */
module exec_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  exec_op_pkg::fu_op_t issue_op_i,
    input  exec_cfg_pkg::xlen_t issue_a_i,
    input  exec_cfg_pkg::xlen_t issue_b_i,
    input  exec_cfg_pkg::tid_t  issue_tid_i,
    output logic                busy_o,
    output logic                wb_valid_o,
    output exec_cfg_pkg::tid_t  wb_tid_o,
    output exec_cfg_pkg::xlen_t wb_result_o,
    output logic                wb_branch_o
);
    import exec_cfg_pkg::*;

    logic  alu_valid;
    logic  mult_start;
    logic  alu_wb_valid;
    tid_t  alu_wb_tid;
    xlen_t alu_wb_result;
    logic  alu_wb_branch;
    logic  mult_done;
    tid_t  mult_tid;
    xlen_t mult_result;
    logic  mult_grant;

    // Grant marks the multiply writeback, which frees the unit
    issue_dispatch i_dispatch (
        .clk_i, .rst_n_i, .issue_valid_i, .issue_op_i,
        .mult_release_i (mult_grant),
        .alu_valid_o    (alu_valid),
        .mult_start_o   (mult_start),
        .busy_o
    );

    alu i_alu (
        .clk_i, .rst_n_i,
        .valid_i (alu_valid), .op_i (issue_op_i), .a_i (issue_a_i), .b_i (issue_b_i),
        .tid_i (issue_tid_i), .wb_valid_o (alu_wb_valid), .wb_tid_o (alu_wb_tid),
        .wb_result_o (alu_wb_result), .wb_branch_o (alu_wb_branch)
    );

    serial_mult i_mult (
        .clk_i, .rst_n_i,
        .start_i (mult_start), .a_i (issue_a_i), .b_i (issue_b_i), .tid_i (issue_tid_i),
        .grant_i (mult_grant), .done_o (mult_done), .tid_o (mult_tid),
        .result_o (mult_result)
    );

    wb_arbiter i_arbiter (
        .alu_valid_i (alu_wb_valid), .alu_branch_i (alu_wb_branch),
        .alu_tid_i (alu_wb_tid), .alu_result_i (alu_wb_result),
        .mult_done_i (mult_done), .mult_tid_i (mult_tid), .mult_result_i (mult_result),
        .mult_grant_o (mult_grant), .wb_valid_o, .wb_branch_o, .wb_tid_o, .wb_result_o
    );

endmodule

//--- logic/wb_arbiter.sv
/* Fixed-priority writeback arbiter that puts the ALU above the
   multiplier on the single writeback bus */
module wb_arbiter (
    input  logic                alu_valid_i,
    input  logic                alu_branch_i,
    input  exec_cfg_pkg::tid_t  alu_tid_i,
    input  exec_cfg_pkg::xlen_t alu_result_i,
    input  logic                mult_done_i,
    input  exec_cfg_pkg::tid_t  mult_tid_i,
    input  exec_cfg_pkg::xlen_t mult_result_i,
    output logic                mult_grant_o,
    output logic                wb_valid_o,
    output logic                wb_branch_o,
    output exec_cfg_pkg::tid_t  wb_tid_o,
    output exec_cfg_pkg::xlen_t wb_result_o
);

    logic alu_grant;

    // ALU results cannot wait and always win
    assign alu_grant    = alu_valid_i;
    // Multiply waits for a free slot on the bus
    assign mult_grant_o = mult_done_i && !alu_valid_i;

    assign wb_valid_o = alu_grant || mult_grant_o;

    always_comb begin
        if (alu_grant) begin
            wb_tid_o    = alu_tid_i;
            wb_result_o = alu_result_i;
            wb_branch_o = alu_branch_i;
        end else begin
            wb_tid_o    = mult_tid_i;
            wb_result_o = mult_result_i;
            // A multiply never resolves a branch
            wb_branch_o = 1'b0;
        end
    end

endmodule

//--- logic/serial_mult.sv
/* Iterative shift-add multiplier for the low product word
   The result is held with done_o until the writeback grant */
module serial_mult (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  exec_cfg_pkg::xlen_t a_i,
    input  exec_cfg_pkg::xlen_t b_i,
    input  exec_cfg_pkg::tid_t  tid_i,
    input  logic                grant_i,
    output logic                done_o,
    output exec_cfg_pkg::tid_t  tid_o,
    output exec_cfg_pkg::xlen_t result_o
);
    import exec_cfg_pkg::*;

    logic                 running_q;
    logic [MUL_CNT_W-1:0] cnt_q;
    xlen_t                mcand_q;
    xlen_t                mplier_q;
    xlen_t                acc_q;

    // Control, the start edge already runs the first iteration
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running_q <= 1'b0;
            done_o    <= 1'b0;
            cnt_q     <= '0;
        end else if (start_i) begin
            running_q <= 1'b1;
            cnt_q     <= MUL_CNT_W'(MUL_CYCLES - 1);
        end else if (running_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == MUL_CNT_W'(1)) begin
                running_q <= 1'b0;
                done_o    <= 1'b1;
            end
        end else if (done_o && grant_i) begin
            done_o <= 1'b0;
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q    <= b_i[0] ? a_i : '0;
            mcand_q  <= a_i << 1;
            mplier_q <= b_i >> 1;
            tid_o    <= tid_i;
        end else if (running_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign result_o = acc_q;

    a_done_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o && !grant_i |=> done_o && $stable(result_o) && $stable(tid_o))
        else $error("multiply result dropped before writeback grant");

endmodule

//--- logic/alu.sv
/* Single-cycle integer ALU with branch resolution
   Result, branch flag and id are registered for writeback */
module alu (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  exec_op_pkg::fu_op_t  op_i,
    input  exec_cfg_pkg::xlen_t  a_i,
    input  exec_cfg_pkg::xlen_t  b_i,
    input  exec_cfg_pkg::tid_t   tid_i,
    output logic                 wb_valid_o,
    output exec_cfg_pkg::tid_t   wb_tid_o,
    output exec_cfg_pkg::xlen_t  wb_result_o,
    output logic                 wb_branch_o
);
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    xlen_t           operand_a_rev;
    logic            less;
    xlen_t           result;
    logic            branch_res;

    // ------------------------------
    // Adder
    // ------------------------------
    logic            adder_op_b_negate;
    logic [XLEN:0]   adder_in_a;
    logic [XLEN:0]   operand_b_neg;
    logic [XLEN+1:0] adder_result_ext;
    xlen_t           adder_result;
    logic            adder_z_flag;

    // Subtraction and equality both need a - b
    assign adder_op_b_negate = (op_i == SUB) || (op_i == EQ) || (op_i == NE);

    // Carry in through the extra low bit
    assign adder_in_a       = {a_i, 1'b1};
    assign operand_b_neg    = {b_i, 1'b0} ^ {(XLEN+1){adder_op_b_negate}};
    assign adder_result_ext = adder_in_a + operand_b_neg;
    assign adder_result     = adder_result_ext[XLEN:1];
    assign adder_z_flag     = ~|adder_result;

    // ------------------------------
    // Shifter
    // ------------------------------
    logic          shift_left;
    logic          shift_arithmetic;
    xlen_t         shift_op_a;
    logic [XLEN:0] shift_op_ext;
    logic [XLEN:0] shift_right_result;
    xlen_t         shift_left_result;
    xlen_t         shift_result;

    assign shift_left       = (op_i == SLL);
    assign shift_arithmetic = (op_i == SRA);

    // Bit reversed operand a lets the right shifter do left shifts
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            operand_a_rev[i] = a_i[XLEN-1-i];
        end
    end

    assign shift_op_a   = shift_left ? operand_a_rev : a_i;
    assign shift_op_ext = {shift_arithmetic & shift_op_a[XLEN-1], shift_op_a};

    assign shift_right_result = $unsigned($signed(shift_op_ext) >>> b_i[SHAMT_W-1:0]);

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shift_left_result[i] = shift_right_result[XLEN-1-i];
        end
    end

    assign shift_result = shift_left ? shift_left_result : shift_right_result[XLEN-1:0];

    // ------------------------------
    // Comparison
    // ------------------------------
    always_comb begin
        logic sgn;
        sgn  = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);
        // Sign or zero extend by one bit, then compare signed
        less = $signed({sgn & a_i[XLEN-1], a_i}) < $signed({sgn & b_i[XLEN-1], b_i});
    end

    always_comb begin : branch_resolve
        unique case (op_i)
            EQ:       branch_res = adder_z_flag;
            NE:       branch_res = ~adder_z_flag;
            LTS, LTU: branch_res = less;
            GES, GEU: branch_res = ~less;
            default:  branch_res = 1'b0;
        endcase
    end

    // ------------------------------
    // Result mux
    // ------------------------------
    always_comb begin
        result = '0;
        unique case (op_i)
            ADD, SUB:      result = adder_result;
            ANDL:          result = a_i & b_i;
            ORL:           result = a_i | b_i;
            XORL:          result = a_i ^ b_i;
            SLL, SRL, SRA: result = shift_result;
            SLTS, SLTU:    result = {{(XLEN-1){1'b0}}, less};
            // Branches only produce the flag
            default:       result = '0;
        endcase
    end

    // Writeback register stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_result_o <= result;
            wb_branch_o <= branch_res;
            wb_tid_o    <= tid_i;
        end
    end

    // Reversed right shift must agree with a plain left shift
    a_sll_reverse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && shift_left |-> shift_result == (a_i << b_i[SHAMT_W-1:0]))
        else $error("left shift through the reversed operand is wrong");

endmodule

//--- logic/issue_dispatch.sv
/* Issue dispatch, steers each issued operation to the ALU or the
   multiplier and tracks whether a multiply is in flight */
module issue_dispatch (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  exec_op_pkg::fu_op_t issue_op_i,
    input  logic                mult_release_i,
    output logic                alu_valid_o,
    output logic                mult_start_o,
    output logic                busy_o
);
    import exec_op_pkg::*;
    import exec_cfg_pkg::*;

    fu_sel_t fu_sel;
    logic    busy_q;

    // Everything except MUL executes in the ALU
    assign fu_sel = (issue_op_i == MUL) ? FU_MUL : FU_ALU;

    assign alu_valid_o  = issue_valid_i && (fu_sel == FU_ALU);
    assign mult_start_o = issue_valid_i && (fu_sel == FU_MUL);

    // Occupancy, set by a start and cleared by the multiply writeback
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (mult_start_o) begin
            busy_q <= 1'b1;
        end else if (mult_release_i) begin
            busy_q <= 1'b0;
        end
    end

    assign busy_o = busy_q;

    // Only one multiply may be in flight
    a_no_mul_while_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mult_start_o |-> !busy_q)
        else $error("multiply issued while the multiplier is occupied");

    // Writeback cannot release the unit before all iterations ran
    a_busy_min_len : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mult_start_o |=> busy_q [*MUL_CYCLES])
        else $error("multiply released before MUL_CYCLES iterations");

endmodule

//--- logic/exec_op_pkg.sv
/* Execute stage operation encoding
   Operation codes and functional-unit selection */
package exec_op_pkg;

    // ------------------------------
    // Operations
    // ------------------------------
    typedef enum logic [4:0] {
        // Adder
        ADD, SUB,
        // Bitwise logic
        ANDL, ORL, XORL,
        // Shifts
        SLL, SRL, SRA,
        // Set less than
        SLTS, SLTU,
        // Branch comparisons, flag only
        EQ, NE, LTS, LTU, GES, GEU,
        // Low word of the product
        MUL
    } fu_op_t;

    // ------------------------------
    // Functional units
    // ------------------------------
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_sel_t;

endpackage

//--- logic/exec_cfg_pkg.sv
/* Execute stage configuration
   Data word, transaction id and multiplier sizing */
package exec_cfg_pkg;

    // Operand and result width
    localparam int unsigned XLEN = 32;
    // Shift amount width, log2 of the word width
    localparam int unsigned SHAMT_W = $clog2(XLEN);

    // Transaction id width, eight operations in flight
    localparam int unsigned TID_W = 3;

    // One iteration per multiplier bit
    localparam int unsigned MUL_CYCLES = 32;
    // Width of the iteration counter
    localparam int unsigned MUL_CNT_W = $clog2(MUL_CYCLES);

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [TID_W-1:0] tid_t;

endpackage
